// File: flist.f
logic/cpu_pkg.sv
logic/register_file.sv
logic/decode_control.sv
logic/hazard_forward.sv
logic/alu.sv
logic/cpu_core.sv
sim/cpu_sva.sv
sim/cpu_tb.sv

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic [word_width-1:0] a,
    input  logic [word_width-1:0] b,
    input  alu_op_t               op,
    output logic [word_width-1:0] result
);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_not:    result = ~a;
            alu_tcp:    result = ~a + 1'b1;
            alu_shl:    result = {a[word_width-2:0], 1'b0};
            alu_shr:    result = {a[word_width-1], a[word_width-1:1]};  // Keeps sign
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    output logic                  read_m1,
    output logic [word_width-1:0] address1,
    input  logic [word_width-1:0] data1,
    output logic                  read_m2,
    output logic                  write_m2,
    output logic [word_width-1:0] address2,
    output logic [word_width-1:0] write_data2,
    input  logic [word_width-1:0] read_data2,
    output logic [word_width-1:0] num_inst,
    output logic [word_width-1:0] output_port,
    output logic                  is_halted
);

    // IF and IF/ID
    logic [word_width-1:0] pc;
    logic                  fetch_started, halt_seen;
    logic [word_width-1:0] if_id_inst;
    logic                  if_id_valid;

    // ID
    logic dec_alu_src, dec_mem_read, dec_mem_write, dec_mem_to_reg;
    logic dec_reg_write, dec_dest_is_rd, dec_wwd, dec_halt;
    alu_op_t                   dec_alu_op;
    logic [reg_addr_width-1:0] id_rs, id_rt, id_rd, id_dest;
    logic [word_width-1:0]     id_read_a, id_read_b, id_imm;
    logic [imm_width-1:0]      imm;
    logic                      stall, issue, halt_in_id;

    // ID/EX
    logic id_ex_valid, id_ex_alu_src, id_ex_mem_read, id_ex_mem_write, id_ex_mem_to_reg;
    logic id_ex_reg_write, id_ex_wwd, id_ex_halt;
    alu_op_t                   id_ex_alu_op;
    logic [reg_addr_width-1:0] id_ex_rs, id_ex_rt, id_ex_dest;
    logic [word_width-1:0]     id_ex_read_a, id_ex_read_b, id_ex_imm;

    // EX
    fwd_sel_t              fwd_a, fwd_b;
    logic [word_width-1:0] op_a, op_b, alu_b, ex_result;

    // EX/MEM and MEM/WB
    logic ex_mem_valid, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg;
    logic ex_mem_reg_write, ex_mem_wwd, ex_mem_halt;
    logic [reg_addr_width-1:0] ex_mem_dest, mem_wb_dest;
    logic [word_width-1:0]     ex_mem_alu_out, ex_mem_data;
    logic mem_wb_valid, mem_wb_mem_to_reg, mem_wb_reg_write, mem_wb_wwd, mem_wb_halt;
    logic [word_width-1:0]     mem_wb_alu_out, mem_wb_data, wb_value;

    ////////////////////
    // IF

    assign read_m1  = fetch_started && !halt_seen;
    assign address1 = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc            <= '0;
            fetch_started <= 1'b0;
            halt_seen     <= 1'b0;
            if_id_inst    <= nop_inst;
            if_id_valid   <= 1'b0;
        end else begin
            fetch_started <= 1'b1;
            if (halt_in_id) halt_seen <= 1'b1;  // Nothing behind HLT gets in
            if (!stall) begin
                if_id_valid <= read_m1 && !halt_in_id;
                if (read_m1) begin
                    if_id_inst <= data1;
                    pc         <= pc + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // ID

    assign id_rs   = if_id_inst[rs_msb:rs_lsb];
    assign id_rt   = if_id_inst[rt_msb:rt_lsb];
    assign id_rd   = if_id_inst[rd_msb:rd_lsb];
    assign imm     = if_id_inst[imm_msb:imm_lsb];
    assign id_dest = dec_dest_is_rd ? id_rd : id_rt;

    assign issue      = if_id_valid && !stall;
    assign halt_in_id = issue && dec_halt;

    always_comb begin
        case (if_id_inst[opcode_msb:opcode_lsb])
            op_ori:  id_imm = {{(word_width-imm_width){1'b0}}, imm};
            op_lhi:  id_imm = {imm, {(word_width-imm_width){1'b0}}};
            default: id_imm = {{(word_width-imm_width){imm[imm_width-1]}}, imm};
        endcase
    end

    decode_control u_decode (
        .inst(if_id_inst), .alu_src(dec_alu_src), .mem_read(dec_mem_read),
        .mem_write(dec_mem_write), .mem_to_reg(dec_mem_to_reg), .reg_write(dec_reg_write),
        .dest_is_rd(dec_dest_is_rd), .wwd(dec_wwd), .halt(dec_halt), .alu_op(dec_alu_op)
    );

    register_file u_regs (
        .clk(clk), .reset_n(reset_n), .read_addr_a(id_rs), .read_addr_b(id_rt),
        .write_addr(mem_wb_dest), .write_en(mem_wb_reg_write), .write_data(wb_value),
        .read_data_a(id_read_a), .read_data_b(id_read_b)
    );

    hazard_forward u_hazard (
        .id_rs(id_rs), .id_rt(id_rt), .ex_rs(id_ex_rs), .ex_rt(id_ex_rt),
        .ex_dest(id_ex_dest), .mem_dest(ex_mem_dest), .wb_dest(mem_wb_dest),
        .ex_mem_read(id_ex_mem_read), .mem_reg_write(ex_mem_reg_write),
        .wb_reg_write(mem_wb_reg_write), .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
    );

    ////////////////////
    // EX

    always_comb begin
        case (fwd_a)
            from_mem: op_a = ex_mem_alu_out;
            from_wb:  op_a = wb_value;
            default:  op_a = id_ex_read_a;
        endcase
        case (fwd_b)
            from_mem: op_b = ex_mem_alu_out;
            from_wb:  op_b = wb_value;
            default:  op_b = id_ex_read_b;
        endcase
    end

    assign alu_b = id_ex_alu_src ? id_ex_imm : op_b;

    alu u_alu (.a(op_a), .b(alu_b), .op(id_ex_alu_op), .result(ex_result));

    ////////////////////
    // MEM and WB

    assign read_m2     = ex_mem_mem_read;
    assign write_m2    = ex_mem_mem_write;
    assign address2    = ex_mem_alu_out;
    assign write_data2 = ex_mem_data;
    assign wb_value    = mem_wb_mem_to_reg ? mem_wb_data : mem_wb_alu_out;

    // Pipeline control, bubble on stall or empty slot
    always_ff @(posedge clk) begin
        if (reset_n) begin
            {id_ex_valid, id_ex_alu_src, id_ex_mem_read, id_ex_mem_write} <= '0;
            {id_ex_mem_to_reg, id_ex_reg_write, id_ex_wwd, id_ex_halt} <= '0;
            {ex_mem_valid, ex_mem_mem_read, ex_mem_mem_write, ex_mem_mem_to_reg} <= '0;
            {ex_mem_reg_write, ex_mem_wwd, ex_mem_halt} <= '0;
            {mem_wb_valid, mem_wb_mem_to_reg, mem_wb_reg_write, mem_wb_wwd, mem_wb_halt} <= '0;
        end else begin
            id_ex_valid       <= issue;
            id_ex_alu_src     <= dec_alu_src;
            id_ex_mem_read    <= issue && dec_mem_read;
            id_ex_mem_write   <= issue && dec_mem_write;
            id_ex_mem_to_reg  <= dec_mem_to_reg;
            id_ex_reg_write   <= issue && dec_reg_write;
            id_ex_wwd         <= issue && dec_wwd;
            id_ex_halt        <= issue && dec_halt;
            ex_mem_valid      <= id_ex_valid;
            ex_mem_mem_read   <= id_ex_mem_read;
            ex_mem_mem_write  <= id_ex_mem_write;
            ex_mem_mem_to_reg <= id_ex_mem_to_reg;
            ex_mem_reg_write  <= id_ex_reg_write;
            ex_mem_wwd        <= id_ex_wwd;
            ex_mem_halt       <= id_ex_halt;
            mem_wb_valid      <= ex_mem_valid;
            mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
            mem_wb_reg_write  <= ex_mem_reg_write;
            mem_wb_wwd        <= ex_mem_wwd;
            mem_wb_halt       <= ex_mem_halt;
        end
    end

    always_ff @(posedge clk) begin
        id_ex_alu_op   <= dec_alu_op;
        id_ex_rs       <= id_rs;
        id_ex_rt       <= id_rt;
        id_ex_dest     <= id_dest;
        id_ex_read_a   <= id_read_a;
        id_ex_read_b   <= id_read_b;
        id_ex_imm      <= id_imm;
        ex_mem_dest    <= id_ex_dest;
        ex_mem_alu_out <= ex_result;
        ex_mem_data    <= id_ex_wwd ? op_a : op_b;  // WWD operand or store data
        mem_wb_dest    <= ex_mem_dest;
        mem_wb_alu_out <= ex_mem_alu_out;
        mem_wb_data    <= ex_mem_mem_read ? read_data2 : ex_mem_data;
    end

    // Retire
    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst    <= '0;
            output_port <= '0;
            is_halted   <= 1'b0;
        end else begin
            if (mem_wb_valid) num_inst <= num_inst + 1'b1;
            if (mem_wb_wwd) output_port <= mem_wb_data;
            if (mem_wb_halt) is_halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Widths

    localparam int word_width     = 16;
    localparam int reg_addr_width = 2;
    localparam int num_regs       = 4;
    localparam int imm_width      = 8;
    localparam int opcode_width   = 4;
    localparam int funct_width    = 6;

    ////////////////////
    // Instruction fields

    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int funct_msb  = 5;
    localparam int funct_lsb  = 0;
    localparam int imm_msb    = 7;
    localparam int imm_lsb    = 0;

    ////////////////////
    // Opcodes and function codes

    localparam logic [opcode_width-1:0] op_adi   = 4'd4;
    localparam logic [opcode_width-1:0] op_ori   = 4'd5;
    localparam logic [opcode_width-1:0] op_lhi   = 4'd6;
    localparam logic [opcode_width-1:0] op_lwd   = 4'd7;
    localparam logic [opcode_width-1:0] op_swd   = 4'd8;
    localparam logic [opcode_width-1:0] op_rtype = 4'd15;

    localparam logic [funct_width-1:0] fn_add = 6'd0;
    localparam logic [funct_width-1:0] fn_sub = 6'd1;
    localparam logic [funct_width-1:0] fn_and = 6'd2;
    localparam logic [funct_width-1:0] fn_orr = 6'd3;
    localparam logic [funct_width-1:0] fn_not = 6'd4;
    localparam logic [funct_width-1:0] fn_tcp = 6'd5;
    localparam logic [funct_width-1:0] fn_shl = 6'd6;
    localparam logic [funct_width-1:0] fn_shr = 6'd7;
    localparam logic [funct_width-1:0] fn_wwd = 6'd28;
    localparam logic [funct_width-1:0] fn_hlt = 6'd29;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_tcp,
        alu_shl,
        alu_shr,
        alu_pass_b    // Load-high
    } alu_op_t;

    typedef enum logic [1:0] {
        from_reg,
        from_mem,
        from_wb
    } fwd_sel_t;

    localparam logic [word_width-1:0] nop_inst = 16'hb000;  // Unused opcode

endpackage

`default_nettype wire

// File: logic/decode_control.sv
`timescale 1ns/100ps
`default_nettype none

module decode_control import cpu_pkg::*; (
    input  logic [word_width-1:0] inst,
    output logic                  alu_src,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  mem_to_reg,
    output logic                  reg_write,
    output logic                  dest_is_rd,
    output logic                  wwd,
    output logic                  halt,
    output alu_op_t               alu_op
);

    logic [opcode_width-1:0] opcode;
    logic [funct_width-1:0]  funct;

    assign opcode = inst[opcode_msb:opcode_lsb];
    assign funct  = inst[funct_msb:funct_lsb];

    always_comb begin
        // Anything not listed falls out as a no-op
        alu_src    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        dest_is_rd = 1'b0;
        wwd        = 1'b0;
        halt       = 1'b0;
        alu_op     = alu_add;

        case (opcode)
            op_rtype: begin
                dest_is_rd = 1'b1;
                reg_write  = 1'b1;
                case (funct)
                    fn_add:  alu_op = alu_add;
                    fn_sub:  alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_orr:  alu_op = alu_or;
                    fn_not:  alu_op = alu_not;
                    fn_tcp:  alu_op = alu_tcp;
                    fn_shl:  alu_op = alu_shl;
                    fn_shr:  alu_op = alu_shr;
                    fn_wwd: begin
                        reg_write = 1'b0;
                        wwd       = 1'b1;
                    end
                    fn_hlt: begin
                        reg_write = 1'b0;
                        halt      = 1'b1;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            op_adi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            op_ori: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = alu_or;
            end
            op_lhi: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
                alu_op    = alu_pass_b;   // Immediate already in upper byte
            end
            op_lwd: begin
                alu_src    = 1'b1;
                mem_read   = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
            end
            op_swd: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/hazard_forward.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_forward import cpu_pkg::*; (
    input  logic [reg_addr_width-1:0] id_rs,
    input  logic [reg_addr_width-1:0] id_rt,
    input  logic [reg_addr_width-1:0] ex_rs,
    input  logic [reg_addr_width-1:0] ex_rt,
    input  logic [reg_addr_width-1:0] ex_dest,
    input  logic [reg_addr_width-1:0] mem_dest,
    input  logic [reg_addr_width-1:0] wb_dest,
    input  logic                      ex_mem_read,
    input  logic                      mem_reg_write,
    input  logic                      wb_reg_write,
    output fwd_sel_t                  fwd_a,
    output fwd_sel_t                  fwd_b,
    output logic                      stall
);

    // Newest producer wins
    function automatic fwd_sel_t pick_source(
        input logic [reg_addr_width-1:0] src,
        input logic [reg_addr_width-1:0] m_dest,
        input logic                      m_write,
        input logic [reg_addr_width-1:0] w_dest,
        input logic                      w_write
    );
        fwd_sel_t sel;
        sel = from_reg;
        if (m_write && m_dest == src) begin
            sel = from_mem;
        end else if (w_write && w_dest == src) begin
            sel = from_wb;
        end
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_source(ex_rs, mem_dest, mem_reg_write, wb_dest, wb_reg_write);
        fwd_b = pick_source(ex_rt, mem_dest, mem_reg_write, wb_dest, wb_reg_write);
    end

    ////////////////////
    // Load-use

    // Loaded value only exists after MEM, so hold ID for one cycle
    assign stall = ex_mem_read && (ex_dest == id_rs || ex_dest == id_rt);

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [reg_addr_width-1:0] read_addr_a,
    input  logic [reg_addr_width-1:0] read_addr_b,
    input  logic [reg_addr_width-1:0] write_addr,
    input  logic                      write_en,
    input  logic [word_width-1:0]     write_data,
    output logic [word_width-1:0]     read_data_a,
    output logic [word_width-1:0]     read_data_b
);

    logic [word_width-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_addr] <= write_data;
        end
    end

    // Write-through so WB and ID can share a cycle
    always_comb begin
        if (write_en && write_addr == read_addr_a) begin
            read_data_a = write_data;
        end else begin
            read_data_a = regs[read_addr_a];
        end

        if (write_en && write_addr == read_addr_b) begin
            read_data_b = write_data;
        end else begin
            read_data_b = regs[read_addr_b];
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module cpu_tb -f flist.f --Mdir "$build_dir" -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$build_dir/cpu_sim" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$log_file"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// File: sim/cpu_sva.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_sva (
    input logic clk,
    input logic reset_n,
    input logic read_m2,
    input logic write_m2,
    input logic is_halted,
    input logic stall
);

    ////////////////////
    // Halt flag

    // Only reset clears it
    halt_sticky: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |=> is_halted
    ) else $error("is_halted fell while out of reset");

    ////////////////////
    // Data port

    port_exclusive: assert property (
        @(posedge clk) disable iff (reset_n) !(read_m2 && write_m2)
    ) else $error("read_m2 and write_m2 high in the same cycle");

    ////////////////////
    // Load-use

    stall_single: assert property (
        @(posedge clk) disable iff (reset_n) stall |=> !stall
    ) else $error("stall held for two consecutive cycles");  // One bubble per load

endmodule

`default_nettype wire

// File: sim/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int clk_half     = 50;
    localparam int drive_delay  = 10;
    localparam int reset_cycles = 4;
    localparam int mem_words    = 256;

    // Golden file layout
    localparam int gold_prog_len  = 'h40;
    localparam int gold_retired   = 'h41;
    localparam int gold_store_adr = 'h42;
    localparam int gold_out_count = 'h43;
    localparam int gold_out_base  = 'h44;

    logic                  clk;
    logic                  reset_n;
    logic                  read_m1, read_m2, write_m2, is_halted;
    logic [word_width-1:0] address1, data1, address2, write_data2, read_data2;
    logic [word_width-1:0] num_inst, output_port;

    logic [word_width-1:0] mem [mem_words];
    logic [word_width-1:0] golden [128];
    logic [word_width-1:0] out_seen [$];
    logic [word_width-1:0] store_seen [$];
    logic [word_width-1:0] last_out = '0;

    int    timeout_cycles  = 0;
    int    error_count     = 0;
    int    tests_passed    = 0;
    int    tests_failed    = 0;
    int    errors_at_start = 0;
    string test_name;

    cpu_core uut (
        .clk(clk), .reset_n(reset_n),
        .read_m1(read_m1), .address1(address1), .data1(data1),
        .read_m2(read_m2), .write_m2(write_m2), .address2(address2),
        .write_data2(write_data2), .read_data2(read_data2),
        .num_inst(num_inst), .output_port(output_port), .is_halted(is_halted)
    );

    bind cpu_core cpu_sva u_sva (
        .clk(clk), .reset_n(reset_n), .read_m2(read_m2), .write_m2(write_m2),
        .is_halted(is_halted), .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half) clk = ~clk;
    end

    ////////////////////
    // Memory model

    assign data1      = mem[address1[7:0]];  // Both ports answer in the same cycle
    assign read_data2 = read_m2 ? mem[address2[7:0]] : 'x;  // Undriven unless read_m2

    always @(posedge clk) begin
        if (write_m2) begin
            mem[address2[7:0]] <= write_data2;
        end
    end

    // Each change of the output port is one retired WWD
    always @(negedge clk) begin
        if (reset_n === 1'b0 && output_port !== last_out) begin
            out_seen.push_back(output_port);
            last_out = output_port;
        end
        if (reset_n === 1'b0 && write_m2 === 1'b1) begin
            store_seen.push_back(address2);
        end
    end

    ////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [word_width-1:0] expected,
                               input logic [word_width-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s / %s: expected %h, actual %h", test_name, name, expected,
                     actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
    endtask

    task automatic report_test();
        if (error_count == errors_at_start) begin
            tests_passed++;
            $display("[PASS] %s", test_name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s (%0d errors)", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic load_memory();
        int prog_len;
        $readmemh("sim/program_golden.hex", golden);
        prog_len = int'(golden[gold_prog_len]);
        for (int i = 0; i < mem_words; i++) begin
            if (i < prog_len) begin
                mem[i] <= golden[i];
            end else begin
                mem[i] <= 16'ha500 | 16'(i);  // Unused opcode tagged with its address
            end
        end
        timeout_cycles = reset_cycles + 4 * prog_len + 100;
    endtask

    ////////////////////
    // Tests

    initial begin
        int exp_count;
        reset_n = 1'b1;
        load_memory();

        start_test("reset_state");
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("num_inst in reset", 16'h0000, num_inst);
        check_value("output_port in reset", 16'h0000, output_port);
        check_value("is_halted in reset", 16'h0000, 16'(is_halted));
        repeat (reset_cycles - 2) @(posedge clk);
        #(drive_delay);
        reset_n = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("num_inst after reset", 16'h0000, num_inst);
        check_value("output_port after reset", 16'h0000, output_port);
        check_value("is_halted after reset", 16'h0000, 16'(is_halted));
        report_test();

        while (is_halted !== 1'b1) @(negedge clk);  // Until HLT retires

        start_test("retired_count");
        check_value("num_inst at halt", golden[gold_retired], num_inst);
        check_value("read_m1 after halt", 16'h0000, 16'(read_m1));
        report_test();

        start_test("halt_sticky");
        repeat (5) @(negedge clk);
        check_value("is_halted later", 16'h0001, 16'(is_halted));
        check_value("num_inst later", golden[gold_retired], num_inst);
        report_test();

        start_test("wwd_outputs");
        exp_count = int'(golden[gold_out_count]);
        check_value("output change count", 16'(exp_count), 16'(out_seen.size()));
        for (int i = 0; i < exp_count && i < out_seen.size(); i++) begin
            check_value($sformatf("output %0d", i), golden[gold_out_base + i], out_seen[i]);
        end
        report_test();

        start_test("store_address");
        if (store_seen.size() == 0) begin
            $display("store_address: no store ever reached the data port");
            error_count++;
        end else begin
            check_value("write_m2 address", golden[gold_store_adr], store_seen[0]);
        end
        report_test();

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the CPU did not halt within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/program_golden.hex
// 0x00: program words. 0x40: program length, expected num_inst, expected store
// address, number of output_port values, then the output_port values in order
@00
6112 5534 42FD F41C   // lhi r1, ori r1, adi r2 -3, wwd r1
F81C F6C0 FC1C F6C1   // wwd r2, add r3, wwd r3, sub r3
FC1C F6C2 FC1C F6C3   // wwd r3, and r3, wwd r3, or r3
FC1C F4C4 FC1C F4C5   // wwd r3, not r3, wwd r3, tcp r3
FC1C F4C6 FC1C F4C7   // wwd r3, shl r3, wwd r3, shr r3
FC1C 4040 8102 7202   // wwd r3, adi r0, swd r1, lwd r2
F81C F8C1 FC1C F01D   // wwd r2 after load, sub r3, wwd r3, hlt
@40
001C                  // program words
001C                  // retired instructions up to HLT
0042                  // store address
000C                  // output_port values
1234 FFFD 1231 1237
1234 FFFD EDCB EDCC
2468 091A 1234 11F4
